/* common/tcb_pkg.sv */
////////////////////////////////////////////////////////////
// shared constants and types for the TCB memory subsystem
// request, response and address layouts used on every stage
////////////////////////////////////////////////////////////

package tcb_pkg;

  //////////////////////////////////////////////////////////
  // bus and memory geometry
  //////////////////////////////////////////////////////////

  // data bus width and byte lanes
  localparam int unsigned DAT_W = 32;
  localparam int unsigned BEN_W = DAT_W / 8;
  // byte offset within a word
  localparam int unsigned OFF_W = $clog2(BEN_W);
  // byte address width
  localparam int unsigned ADR_W = 12;
  // word address per bank
  localparam int unsigned MEM_ADR_W = ADR_W - OFF_W;
  // log size field, 0..2 legal
  localparam int unsigned SIZ_W = 2;
  // entries in each byte bank
  localparam int unsigned MEM_DEPTH = 2 ** MEM_ADR_W;

  //////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////

  // one byte lane
  typedef logic [7:0] byte_t;

  // word address and offset view
  typedef struct packed {
    logic [MEM_ADR_W-1:0] wrd;
    logic [OFF_W-1:0]     off;
  } tcb_wrd_off_t;

  // byte address, or split into word and offset
  typedef union packed {
    logic [ADR_W-1:0] byte_adr;
    tcb_wrd_off_t     wrd_off;
  } tcb_adr_u;

  // log size mode request
  typedef struct packed {
    logic             wen;
    tcb_adr_u         adr;
    logic [SIZ_W-1:0] siz;
    logic [DAT_W-1:0] wdt;
  } tcb_siz_req_t;

  // byte enable mode request, data already on lanes
  typedef struct packed {
    logic             wen;
    tcb_adr_u         adr;
    logic [BEN_W-1:0] ben;
    logic [DAT_W-1:0] wdt;
  } tcb_ben_req_t;

  // response data, right justified, zero filled
  typedef struct packed {
    logic [DAT_W-1:0] rdt;
  } tcb_rsp_t;

endpackage

/* rtl/tcb_size_to_ben.sv */
////////////////////////////////////////////////////////////
// log size to byte enable request conversion
// combinational, rotates write bytes onto their lanes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_size_to_ben (
  // clock and reset, only for the check below
  input  logic                 clk,
  input  logic                 rst,
  // log size request
  input  logic                 vld,
  input  tcb_pkg::tcb_siz_req_t req,
  // byte enable request
  output tcb_pkg::tcb_ben_req_t ben_req
);

  //////////////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////////////

  always_comb begin
    // byte index within the transfer seen by a lane
    logic [tcb_pkg::OFF_W-1:0] rel;
    rel = '0;
    // control fields pass unchanged
    ben_req.wen = req.wen;
    ben_req.adr = req.adr;
    ben_req.ben = '0;
    ben_req.wdt = '0;
    for (int i = 0; i < tcb_pkg::BEN_W; i++) begin
      // lane i carries transfer byte (i - off) mod 4
      rel = tcb_pkg::OFF_W'(i) - req.adr.wrd_off.off;
      // enabled while that byte is within the size
      ben_req.ben[i] = (int'(rel) < (1 << req.siz));
      // write byte rel lands on lane i
      ben_req.wdt[8*i +: 8] = req.wdt[8*rel +: 8];
    end
  end

  //////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////

  // size 3 would need 8 lanes, not on a 32 bit bus
  siz_legal_a: assert property (
    @(posedge clk) disable iff (rst)
    vld |-> (req.siz != 2'd3)
  ) else $error("illegal request size 3");

endmodule

/* tcb_mem/tcb_misaligned_memory_controller.sv */
////////////////////////////////////////////////////////////
// byte enable request to per lane SRAM controls
// lanes below the offset address the following word
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_misaligned_memory_controller (
  input  logic                                              clk,
  input  logic                                              rst,
  // byte enable request
  input  logic                                              vld,
  input  tcb_pkg::tcb_ben_req_t                             ben_req,
  // SRAM side, one entry per lane
  output logic [tcb_pkg::BEN_W-1:0]                         mem_cen,
  output logic                                              mem_wen,
  output logic [tcb_pkg::BEN_W-1:0][tcb_pkg::MEM_ADR_W-1:0] mem_adr,
  output tcb_pkg::byte_t [tcb_pkg::BEN_W-1:0]               mem_wdt
);

  //////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////

  // word address and its successor
  logic [tcb_pkg::MEM_ADR_W-1:0] wrd;
  logic [tcb_pkg::MEM_ADR_W-1:0] nxt;
  // byte offset in the word
  logic [tcb_pkg::OFF_W-1:0]     off;

  assign wrd = ben_req.adr.wrd_off.wrd;
  assign off = ben_req.adr.wrd_off.off;
  // top word wraps into word 0
  assign nxt = wrd + 1'b1;

  //////////////////////////////////////////////////////////
  // lane controls
  //////////////////////////////////////////////////////////

  // only enabled lanes of a valid request
  assign mem_cen = {tcb_pkg::BEN_W{vld}} & ben_req.ben;
  // same direction on all banks
  assign mem_wen = ben_req.wen;

  for (genvar i = 0; i < tcb_pkg::BEN_W; i++) begin : g_lane
    // wrapped bytes sit below the offset
    assign mem_adr[i] = (i < off) ? nxt : wrd;
    // data is already lane ordered
    assign mem_wdt[i] = ben_req.wdt[8*i +: 8];
  end

  // a valid request always touches at least one bank
  cen_any_a: assert property (
    @(posedge clk) disable iff (rst)
    vld |-> (mem_cen != '0)
  ) else $error("valid request without any chip enable");

endmodule

/* tcb_mem/sram_byte_bank.sv */
////////////////////////////////////////////////////////////
// byte wide synchronous SRAM bank, one per lane
// read data registered, held between reads
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_byte_bank (
  input  logic                          clk,
  // access controls
  input  logic                          cen,
  input  logic                          wen,
  input  logic [tcb_pkg::MEM_ADR_W-1:0] adr,
  // data
  input  tcb_pkg::byte_t                wdt,
  output tcb_pkg::byte_t                rdt
);

  // storage array
  tcb_pkg::byte_t mem [tcb_pkg::MEM_DEPTH];

  // write or registered read, one cycle latency
  always_ff @(posedge clk) begin
    if (cen) begin
      if (wen) begin
        mem[adr] <= wdt;
      end else begin
        rdt <= mem[adr];
      end
    end
  end

endmodule

/* rtl/tcb_rsp_align.sv */
////////////////////////////////////////////////////////////
// response stage that realigns read lanes to the request
// offset and size are held one cycle for the rotate and mask
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_rsp_align (
  input  logic                                  clk,
  input  logic                                  rst,
  // request as seen at the banks
  input  logic                                  vld,
  input  tcb_pkg::tcb_siz_req_t                 req,
  // bank read lanes
  input  tcb_pkg::byte_t [tcb_pkg::BEN_W-1:0]   mem_rdt,
  // response
  output logic                                  rsp_vld,
  output tcb_pkg::tcb_rsp_t                     rsp
);

  // read strobe of the current request
  logic                      rd_req;
  // delayed request fields
  logic                      rd_q;
  logic [tcb_pkg::OFF_W-1:0] off_q;
  logic [tcb_pkg::SIZ_W-1:0] siz_q;

  assign rd_req = vld & ~req.wen;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_req;
    end
  end

  // shape of the access for the realign
  always_ff @(posedge clk) begin
    off_q <= req.adr.wrd_off.off;
    siz_q <= req.siz;
  end

  //////////////////////////////////////////////////////////
  // realign
  //////////////////////////////////////////////////////////

  assign rsp_vld = rd_q;

  always_comb begin
    // bank lane holding result byte j
    logic [tcb_pkg::OFF_W-1:0] lane;
    lane = '0;
    rsp.rdt = '0;
    for (int j = 0; j < tcb_pkg::BEN_W; j++) begin
      lane = off_q + tcb_pkg::OFF_W'(j);
      // zero above the access size
      rsp.rdt[8*j +: 8] = (j < (1 << siz_q)) ? mem_rdt[lane] : 8'h00;
    end
  end

  // read data from the banks is fully known in the response cycle
  rsp_known_a: assert property (
    @(posedge clk) disable iff (rst)
    rsp_vld |-> !$isunknown(rsp.rdt)
  ) else $error("read response with unknown data");

endmodule

/* rtl/tcb_mem_top.sv */
////////////////////////////////////////////////////////////
// TCB memory subsystem top, log size requests in
// one cycle read responses out, writes give no response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_mem_top (
  input  logic                  clk,
  input  logic                  rst,
  // manager request
  input  logic                  req_vld,
  input  tcb_pkg::tcb_siz_req_t req,
  // read response
  output logic                  rsp_vld,
  output tcb_pkg::tcb_rsp_t     rsp
);

  // byte enable request
  tcb_pkg::tcb_ben_req_t                             ben_req;
  // bank wiring
  logic [tcb_pkg::BEN_W-1:0]                         mem_cen;
  logic                                              mem_wen;
  logic [tcb_pkg::BEN_W-1:0][tcb_pkg::MEM_ADR_W-1:0] mem_adr;
  tcb_pkg::byte_t [tcb_pkg::BEN_W-1:0]               mem_wdt;
  tcb_pkg::byte_t [tcb_pkg::BEN_W-1:0]               mem_rdt;

  // size to lanes
  tcb_size_to_ben u_siz2ben (
    .clk     (clk),
    .rst     (rst),
    .vld     (req_vld),
    .req     (req),
    .ben_req (ben_req)
  );

  // lanes to bank controls
  tcb_misaligned_memory_controller u_ctl (
    .clk     (clk),
    .rst     (rst),
    .vld     (req_vld),
    .ben_req (ben_req),
    .mem_cen (mem_cen),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_wdt (mem_wdt)
  );

  // one bank per byte lane
  for (genvar i = 0; i < tcb_pkg::BEN_W; i++) begin : g_bank
    sram_byte_bank u_bank (
      .clk (clk),
      .cen (mem_cen[i]),
      .wen (mem_wen),
      .adr (mem_adr[i]),
      .wdt (mem_wdt[i]),
      .rdt (mem_rdt[i])
    );
  end

  // read lanes back to response order
  tcb_rsp_align u_align (
    .clk     (clk),
    .rst     (rst),
    .vld     (req_vld),
    .req     (req),
    .mem_rdt (mem_rdt),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule

/* verif/tcb_mem_tb.sv */
////////////////////////////////////////////////////////////
// testbench for the TCB memory subsystem with random requests
// checked every cycle against a byte array model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_mem_tb;

  // random op count and cycle budget
  localparam int OPS            = 2000;
  localparam int WORDS          = tcb_pkg::MEM_DEPTH;
  localparam int BYTES          = 2 ** tcb_pkg::ADR_W;
  localparam int TIMEOUT_CYCLES = WORDS + 3 * OPS + 100;

  logic                  clk;
  logic                  rst;
  logic                  req_vld;
  tcb_pkg::tcb_siz_req_t req;
  logic                  rsp_vld;
  tcb_pkg::tcb_rsp_t     rsp;

  // model state
  tcb_pkg::byte_t    ref_mem [BYTES];
  tcb_pkg::tcb_rsp_t exp_q [$];
  tcb_pkg::tcb_rsp_t want_rsp;
  logic              rd_pending = 1'b0;
  logic [31:0]       lfsr_state = 32'h2d736ecb;
  int                cycle_cnt;

  tcb_mem_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken msb first
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // failure and compare
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_vld(input logic got, input logic want);
    if (got !== want) begin
      fail_run($sformatf("ERROR: rsp_vld = %h, expected %h", got, want));
    end
  endtask

  task automatic compare_rsp(input tcb_pkg::tcb_rsp_t got, input tcb_pkg::tcb_rsp_t want);
    if (got !== want) begin
      fail_run($sformatf("ERROR: rsp.rdt = %h, expected %h", got.rdt, want.rdt));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // one request in the next cycle with the model updated at once
  task automatic issue(input tcb_pkg::tcb_siz_req_t r);
    tcb_pkg::tcb_rsp_t want;
    int                a;
    @(posedge clk);
    #2;
    req_vld = 1'b1;
    req     = r;
    want    = '0;
    for (int j = 0; j < (1 << r.siz); j++) begin
      // bytes run on past the top and wrap to 0
      a = (int'(r.adr.byte_adr) + j) % BYTES;
      if (r.wen) begin
        ref_mem[a] = r.wdt[8*j +: 8];
      end else begin
        want.rdt[8*j +: 8] = ref_mem[a];
      end
    end
    if (!r.wen) begin
      exp_q.push_back(want);
    end
  endtask

  task automatic idle();
    @(posedge clk);
    #2;
    req_vld = 1'b0;
  endtask

  task automatic make_req(input logic wen, input int adr, input int siz,
                          input logic [31:0] wdt, output tcb_pkg::tcb_siz_req_t r);
    r              = '0;
    r.wen          = wen;
    r.adr.byte_adr = tcb_pkg::ADR_W'(adr);
    r.siz          = tcb_pkg::SIZ_W'(siz);
    r.wdt          = wdt;
  endtask

  ////////////////////////////////////////////////////////////
  // response checker
  ////////////////////////////////////////////////////////////

  // a read taken at this edge answers in the next cycle
  always @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= req_vld & ~req.wen;
    end
  end

  // mid cycle when outputs have settled
  always @(negedge clk) begin
    if (!rst) begin
      compare_vld(rsp_vld, rd_pending);
      if (rd_pending) begin
        want_rsp = exp_q.pop_front();
        compare_rsp(rsp, want_rsp);
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    fail_run($sformatf("timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    tcb_pkg::tcb_siz_req_t r;
    logic [31:0]           v;
    rst     = 1'b1;
    req_vld = 1'b0;
    req     = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    // prefill with aligned words over the whole memory
    for (int w = 0; w < WORDS; w++) begin
      take_bits(32, v);
      make_req(1'b1, w * 4, 2, v, r);
      issue(r);
    end
    // back to back accesses where the top word wraps into word 0
    make_req(1'b1, BYTES - 2, 2, 32'ha1b2c3d4, r);
    issue(r);
    make_req(1'b0, BYTES - 3, 2, '0, r);
    issue(r);
    make_req(1'b0, BYTES - 1, 1, '0, r);
    issue(r);
    make_req(1'b0, 0, 2, '0, r);
    issue(r);
    idle();
    // random mix with a gap of 0 or 1 idle cycles
    for (int n = 0; n < OPS; n++) begin
      r = '0;
      take_bits(1, v);
      r.wen = v[0];
      take_bits(2, v);
      // illegal size 3 folds onto word
      r.siz = (v[1:0] == 2'd3) ? 2'd2 : v[1:0];
      take_bits(tcb_pkg::ADR_W, v);
      r.adr.byte_adr = v[tcb_pkg::ADR_W-1:0];
      take_bits(32, v);
      r.wdt = v;
      issue(r);
      take_bits(1, v);
      if (v[0]) begin
        idle();
      end
    end
    idle();
    repeat (3) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* verilog.f */
common/tcb_pkg.sv
rtl/tcb_size_to_ben.sv
tcb_mem/tcb_misaligned_memory_controller.sv
tcb_mem/sram_byte_bank.sv
rtl/tcb_rsp_align.sv
rtl/tcb_mem_top.sv
verif/tcb_mem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the TCB memory testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tcb_mem_tb \
  -f verilog.f

# the log decides pass or fail
./obj_dir/Vtcb_mem_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation done"
